// ==== verilog/arm_isa_pkg.sv ====
// ==================================================
// ARM instruction set definitions
// Instruction classes, ALU opcodes, mnemonics and
// the bit positions used by the trace decoder
// ==================================================
`default_nettype none

package arm_isa_pkg;

	// ==================================================
	// Instruction word fields
	// ==================================================
	localparam int OPCODE_MSB = 24;
	localparam int OPCODE_LSB = 21;
	localparam int S_BIT      = 20;
	localparam int LOAD_BIT   = 20;
	localparam int BYTE_BIT   = 22;
	localparam int LINK_BIT   = 24;
	// Multiply accumulate bit shares the position of the opcode LSB
	localparam int ACC_BIT    = 21;
	// Splits coprocessor data ops from register transfers
	localparam int CP_OP_BIT  = 4;

	// Instruction class in the same decode order as the core
	typedef enum logic [3:0] {
		REGOP,
		MULT,
		SWAP,
		TRANS,
		MTRANS,
		BRANCH,
		CODTRANS,
		COREGOP,
		CORTRANS,
		SWI
	} insn_class_e;

	// Data processing opcode in bits 24:21
	typedef enum logic [3:0] {
		AND, EOR, SUB, RSB,
		ADD, ADC, SBC, RSC,
		TST, TEQ, CMP, CMN,
		ORR, MOV, BIC, MVN
	} alu_op_e;

	// One value per traced mnemonic
	typedef enum logic [5:0] {
		MN_ADC, MN_ADD, MN_AND, MN_B,
		MN_BIC, MN_BL, MN_CDP, MN_CMN,
		MN_CMP, MN_EOR, MN_LDC, MN_LDM,
		MN_LDR, MN_LDRB, MN_MCR, MN_MLA,
		MN_MOV, MN_MRC, MN_MUL, MN_MVN,
		MN_ORR, MN_RSB, MN_RSC, MN_SBC,
		MN_STC, MN_STM, MN_STR, MN_STRB,
		MN_SUB, MN_SWI, MN_SWP, MN_SWPB,
		MN_TEQ, MN_TST,
		MN_UNKNOWN
	} mnemonic_e;

endpackage

`default_nettype wire

// ==== verilog/trace_pkg.sv ====
// ==================================================
// Trace record definitions
// Record kinds, per-source records, merged record
// and queue sizing
// ==================================================
`default_nettype none

package trace_pkg;
	import arm_isa_pkg::*;

	localparam int TRACE_QDEPTH = 4;
	localparam int SEQ_W        = 16;
	localparam int QPTR_W       = $clog2(TRACE_QDEPTH);
	// Fill count must also hold the full value
	localparam int QCNT_W       = $clog2(TRACE_QDEPTH + 1);

	typedef enum logic [1:0] {
		TRK_EXEC,
		TRK_MEM_RD,
		TRK_MEM_WR
	} trace_kind_e;

	typedef struct packed {
		logic [31:0] address;
		logic [31:0] instruction;
		insn_class_e insn_class;
		mnemonic_e   mnemonic;
	} exec_rec_t;

	typedef struct packed {
		logic [31:0] address;
		logic [31:0] data;
		logic [3:0]  byte_en;
		logic        is_write;
	} mem_rec_t;

	// Data holds the instruction word for execute records
	typedef struct packed {
		trace_kind_e kind;
		logic [SEQ_W-1:0] seq;
		logic [31:0] address;
		logic [31:0] data;
		logic [3:0]  byte_en;
		insn_class_e insn_class;
		mnemonic_e   mnemonic;
	} trace_rec_t;

endpackage

`default_nettype wire

// ==== verilog/insn_trace_decoder.sv ====
// ==================================================
// Instruction trace decoder
// Moves each accepted fetch into an execute register,
// classifies it and emits one record per instruction
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module insn_trace_decoder
	import arm_isa_pkg::*, trace_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_fetch_stall,
	input  logic        i_instruction_valid,
	input  logic        i_instruction_undefined,
	input  logic [31:0] i_instruction,
	input  logic [31:0] i_instruction_address,
	input  logic [2:0]  i_interrupt,
	output logic        o_exec_valid,
	output exec_rec_t   o_exec
);

	logic        accept;
	logic        ex_now;
	logic [31:0] ex_insn;
	logic [31:0] ex_addr;
	logic        ex_undef;
	logic [2:0]  int_d1;
	logic        int_takeover;
	insn_class_e ex_class;
	alu_op_e     ex_op;
	mnemonic_e   ex_mnem;

	assign accept = i_instruction_valid && !i_fetch_stall;

	// ==================================================
	// Execute stage
	// ==================================================
	always_ff @(posedge i_clk) begin
		if (accept) begin
			ex_insn  <= i_instruction;
			ex_addr  <= i_instruction_address;
			ex_undef <= i_instruction_undefined;
		end
	end

	// Interrupt states 1..6 take over the instruction just starting
	assign int_takeover = (int_d1 != 3'd0) && (int_d1 != 3'd7);

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			ex_now       <= 1'b0;
			int_d1       <= 3'd0;
			o_exec_valid <= 1'b0;
		end else begin
			ex_now       <= accept;
			int_d1       <= i_interrupt;
			o_exec_valid <= ex_now && !int_takeover;
		end
	end

	// ==================================================
	// Classification
	// ==================================================
	assign ex_op = alu_op_e'(ex_insn[OPCODE_MSB:OPCODE_LSB]);

	// Swap and multiply sit inside the regop space, so test them first
	always_comb begin
		if (ex_insn[27:23] == 5'b00010 && ex_insn[21:S_BIT] == 2'b00 &&
				ex_insn[11:4] == 8'b0000_1001)
			ex_class = SWAP;
		else if (ex_insn[27:22] == 6'b000000 && ex_insn[7:4] == 4'b1001)
			ex_class = MULT;
		else if (ex_insn[27:26] == 2'b00)
			ex_class = REGOP;
		else if (ex_insn[27:26] == 2'b01)
			ex_class = TRANS;
		else if (ex_insn[27:25] == 3'b100)
			ex_class = MTRANS;
		else if (ex_insn[27:25] == 3'b101)
			ex_class = BRANCH;
		else if (ex_insn[27:25] == 3'b110)
			ex_class = CODTRANS;
		else if (ex_insn[27:24] == 4'b1110 && !ex_insn[CP_OP_BIT])
			ex_class = COREGOP;
		else if (ex_insn[27:24] == 4'b1110)
			ex_class = CORTRANS;
		else
			ex_class = SWI;
	end

	always_comb begin
		ex_mnem = MN_UNKNOWN;
		case (ex_class)
			REGOP: begin
				case (ex_op)
					AND: ex_mnem = MN_AND;
					EOR: ex_mnem = MN_EOR;
					SUB: ex_mnem = MN_SUB;
					RSB: ex_mnem = MN_RSB;
					ADD: ex_mnem = MN_ADD;
					ADC: ex_mnem = MN_ADC;
					SBC: ex_mnem = MN_SBC;
					RSC: ex_mnem = MN_RSC;
					TST: ex_mnem = MN_TST;
					TEQ: ex_mnem = MN_TEQ;
					CMP: ex_mnem = MN_CMP;
					CMN: ex_mnem = MN_CMN;
					ORR: ex_mnem = MN_ORR;
					MOV: ex_mnem = MN_MOV;
					BIC: ex_mnem = MN_BIC;
					MVN: ex_mnem = MN_MVN;
				endcase
			end
			MULT:     ex_mnem = ex_insn[ACC_BIT] ? MN_MLA : MN_MUL;
			SWAP:     ex_mnem = ex_insn[BYTE_BIT] ? MN_SWPB : MN_SWP;
			TRANS: begin
				case ({ex_insn[BYTE_BIT], ex_insn[LOAD_BIT]})
					2'b00:   ex_mnem = MN_STR;
					2'b01:   ex_mnem = MN_LDR;
					2'b10:   ex_mnem = MN_STRB;
					default: ex_mnem = MN_LDRB;
				endcase
			end
			MTRANS:   ex_mnem = ex_insn[LOAD_BIT] ? MN_LDM : MN_STM;
			BRANCH:   ex_mnem = ex_insn[LINK_BIT] ? MN_BL : MN_B;
			CODTRANS: ex_mnem = ex_insn[LOAD_BIT] ? MN_LDC : MN_STC;
			COREGOP:  ex_mnem = MN_CDP;
			CORTRANS: ex_mnem = ex_insn[LOAD_BIT] ? MN_MRC : MN_MCR;
			SWI:      ex_mnem = MN_SWI;
			default:  ex_mnem = MN_UNKNOWN;
		endcase
		// Undefined words keep their class but no mnemonic
		if (ex_undef)
			ex_mnem = MN_UNKNOWN;
	end

	always_ff @(posedge i_clk) begin
		if (ex_now) begin
			o_exec.address     <= ex_addr;
			o_exec.instruction <= ex_insn;
			o_exec.insn_class  <= ex_class;
			o_exec.mnemonic    <= ex_mnem;
		end
	end

	// Back-to-back pulses need an accept behind each of them
	a_exec_pulse_src: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_exec_valid && $past(o_exec_valid) |-> $past(accept, 2) && $past(accept, 3));

endmodule

`default_nettype wire

// ==== verilog/mem_access_monitor.sv ====
// ==================================================
// Memory access monitor
// One record per unstalled data read or write
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module mem_access_monitor
	import trace_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_fetch_stall,
	input  logic        i_data_access,
	input  logic        i_write_enable,
	input  logic [31:0] i_address,
	input  logic [31:0] i_write_data,
	input  logic [31:0] i_read_data,
	input  logic [3:0]  i_byte_enable,
	output logic        o_mem_valid,
	output mem_rec_t    o_mem
);

	logic rec_wr;
	logic rec_rd;

	// Write wins over read
	assign rec_wr = i_write_enable && !i_fetch_stall;
	assign rec_rd = i_data_access && !i_write_enable && !i_fetch_stall;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n)
			o_mem_valid <= 1'b0;
		else
			o_mem_valid <= rec_wr || rec_rd;
	end

	always_ff @(posedge i_clk) begin
		if (rec_wr || rec_rd) begin
			o_mem.address  <= i_address;
			o_mem.data     <= rec_wr ? i_write_data : i_read_data;
			o_mem.byte_en  <= i_byte_enable;
			o_mem.is_write <= rec_wr;
		end
	end

	// Read record carries read data and is never marked as a write
	a_read_rec: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		rec_rd |=> o_mem_valid && !o_mem.is_write && o_mem.data == $past(i_read_data));

endmodule

`default_nettype wire

// ==== verilog/trace_merger.sv ====
// ==================================================
// Trace merger
// Stamps execute and memory records with a sequence
// number and drains them through one ordered queue
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module trace_merger
	import arm_isa_pkg::*, trace_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_arst_n,
	input  logic       i_exec_valid,
	input  exec_rec_t  i_exec,
	input  logic       i_mem_valid,
	input  mem_rec_t   i_mem,
	output logic       o_trace_valid,
	output trace_rec_t o_trace,
	output logic       o_overflow
);

	trace_rec_t        queue [TRACE_QDEPTH];
	logic [QPTR_W-1:0] rd_ptr;
	logic [QPTR_W-1:0] wr_ptr;
	logic [QPTR_W-1:0] mem_slot;
	logic [QCNT_W-1:0] fill;
	logic [SEQ_W-1:0]  seq_cnt;
	trace_rec_t        exec_rec;
	trace_rec_t        mem_rec;
	logic              exec_push;
	logic              mem_push;
	logic              pop;
	logic [1:0]        n_push;

	// ==================================================
	// Record conversion
	// ==================================================
	always_comb begin
		exec_rec.kind       = TRK_EXEC;
		exec_rec.seq        = seq_cnt;
		exec_rec.address    = i_exec.address;
		exec_rec.data       = i_exec.instruction;
		exec_rec.byte_en    = 4'h0;
		exec_rec.insn_class = i_exec.insn_class;
		exec_rec.mnemonic   = i_exec.mnemonic;

		// Memory record follows the execute record in the same cycle
		mem_rec.kind        = i_mem.is_write ? TRK_MEM_WR : TRK_MEM_RD;
		mem_rec.seq         = seq_cnt + SEQ_W'(i_exec_valid);
		mem_rec.address     = i_mem.address;
		mem_rec.data        = i_mem.data;
		mem_rec.byte_en     = i_mem.byte_en;
		mem_rec.insn_class  = REGOP;
		mem_rec.mnemonic    = MN_UNKNOWN;
	end

	// ==================================================
	// Queue control
	// ==================================================
	assign pop       = (fill != '0);
	assign exec_push = i_exec_valid && (fill < QCNT_W'(TRACE_QDEPTH));
	assign mem_push  = i_mem_valid &&
		((fill + QCNT_W'(exec_push)) < QCNT_W'(TRACE_QDEPTH));
	assign mem_slot  = wr_ptr + QPTR_W'(exec_push);
	assign n_push    = {1'b0, exec_push} + {1'b0, mem_push};

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rd_ptr        <= '0;
			wr_ptr        <= '0;
			fill          <= '0;
			seq_cnt       <= '0;
			o_trace_valid <= 1'b0;
			o_overflow    <= 1'b0;
		end else begin
			o_trace_valid <= pop;
			if (pop)
				rd_ptr <= rd_ptr + QPTR_W'(1);
			wr_ptr <= wr_ptr + QPTR_W'(n_push);
			fill   <= fill + QCNT_W'(n_push) - QCNT_W'(pop);
			// Dropped records still consume a sequence number
			seq_cnt <= seq_cnt + SEQ_W'(i_exec_valid) + SEQ_W'(i_mem_valid);
			if ((i_exec_valid && !exec_push) || (i_mem_valid && !mem_push))
				o_overflow <= 1'b1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (exec_push)
			queue[wr_ptr] <= exec_rec;
		if (mem_push)
			queue[mem_slot] <= mem_rec;
		if (pop)
			o_trace <= queue[rd_ptr];
	end

	a_fill_bound: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		fill <= QCNT_W'(TRACE_QDEPTH));

	// Empty queue has equal pointers and is not full
	a_no_empty_pop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		o_trace_valid |-> $past(rd_ptr != wr_ptr || fill == QCNT_W'(TRACE_QDEPTH)));

endmodule

`default_nettype wire

// ==== verilog/a23_trace_unit.sv ====
// ==================================================
// Execution trace unit top
// Decoder and memory monitor feeding the merger
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module a23_trace_unit
	import trace_pkg::*;
(
	input  logic        i_clk,
	input  logic        i_arst_n,
	input  logic        i_fetch_stall,
	input  logic [31:0] i_instruction,
	input  logic        i_instruction_valid,
	input  logic [31:0] i_instruction_address,
	input  logic        i_instruction_undefined,
	input  logic [2:0]  i_interrupt,
	input  logic        i_data_access,
	input  logic        i_write_enable,
	input  logic [31:0] i_address,
	input  logic [31:0] i_write_data,
	input  logic [31:0] i_read_data,
	input  logic [3:0]  i_byte_enable,
	output logic        o_trace_valid,
	output trace_rec_t  o_trace,
	output logic        o_overflow
);

	logic      exec_valid;
	exec_rec_t exec_rec;
	logic      mem_valid;
	mem_rec_t  mem_rec;

	insn_trace_decoder u_decoder (
		.i_clk                   (i_clk),
		.i_arst_n                (i_arst_n),
		.i_fetch_stall           (i_fetch_stall),
		.i_instruction_valid     (i_instruction_valid),
		.i_instruction_undefined (i_instruction_undefined),
		.i_instruction           (i_instruction),
		.i_instruction_address   (i_instruction_address),
		.i_interrupt             (i_interrupt),
		.o_exec_valid            (exec_valid),
		.o_exec                  (exec_rec)
	);

	mem_access_monitor u_monitor (
		.i_clk          (i_clk),
		.i_arst_n       (i_arst_n),
		.i_fetch_stall  (i_fetch_stall),
		.i_data_access  (i_data_access),
		.i_write_enable (i_write_enable),
		.i_address      (i_address),
		.i_write_data   (i_write_data),
		.i_read_data    (i_read_data),
		.i_byte_enable  (i_byte_enable),
		.o_mem_valid    (mem_valid),
		.o_mem          (mem_rec)
	);

	trace_merger u_merger (
		.i_clk         (i_clk),
		.i_arst_n      (i_arst_n),
		.i_exec_valid  (exec_valid),
		.i_exec        (exec_rec),
		.i_mem_valid   (mem_valid),
		.i_mem         (mem_rec),
		.o_trace_valid (o_trace_valid),
		.o_trace       (o_trace),
		.o_overflow    (o_overflow)
	);

endmodule

`default_nettype wire

// ==== verification/tb_a23_trace_unit.sv ====
// ==================================================
// Testbench for the execution trace unit
// Replays cycles from the stimulus file and checks
// every trace record against the expected list
// ==================================================
`timescale 1ns/1ps
`default_nettype none

module tb_a23_trace_unit
	import arm_isa_pkg::*, trace_pkg::*;
;

	localparam int    CLK_PERIOD = 40;
	localparam string STIM_PATH  = "verification/trace_stim.txt";

	logic        i_clk;
	logic        i_arst_n;
	logic        i_fetch_stall;
	logic [31:0] i_instruction;
	logic        i_instruction_valid;
	logic [31:0] i_instruction_address;
	logic        i_instruction_undefined;
	logic [2:0]  i_interrupt;
	logic        i_data_access;
	logic        i_write_enable;
	logic [31:0] i_address;
	logic [31:0] i_write_data;
	logic [31:0] i_read_data;
	logic [3:0]  i_byte_enable;
	logic        o_trace_valid;
	trace_rec_t  o_trace;
	logic        o_overflow;

	trace_rec_t  exp_q [$];
	int          n_errors;
	int          n_checks;
	int          stim_lines;
	logic [31:0] lfsr;

	a23_trace_unit dut0 (
		.i_clk                   (i_clk),
		.i_arst_n                (i_arst_n),
		.i_fetch_stall           (i_fetch_stall),
		.i_instruction           (i_instruction),
		.i_instruction_valid     (i_instruction_valid),
		.i_instruction_address   (i_instruction_address),
		.i_instruction_undefined (i_instruction_undefined),
		.i_interrupt             (i_interrupt),
		.i_data_access           (i_data_access),
		.i_write_enable          (i_write_enable),
		.i_address               (i_address),
		.i_write_data            (i_write_data),
		.i_read_data             (i_read_data),
		.i_byte_enable           (i_byte_enable),
		.o_trace_valid           (o_trace_valid),
		.o_trace                 (o_trace),
		.o_overflow              (o_overflow)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// ==================================================
	// Random idle gaps
	// ==================================================
	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = (val << 1) | int'(lfsr[0]);
		end
	endtask

	// ==================================================
	// Drivers
	// ==================================================
	task automatic apply_cycle(input logic stall, input logic valid, input logic undef,
			input logic [31:0] iaddr, input logic [31:0] insn, input logic [2:0] intr,
			input logic dacc, input logic we, input logic [31:0] maddr,
			input logic [31:0] wdata, input logic [31:0] rdata, input logic [3:0] be);
		@(posedge i_clk);
		#2;
		i_fetch_stall           = stall;
		i_instruction_valid     = valid;
		i_instruction_undefined = undef;
		i_instruction_address   = iaddr;
		i_instruction           = insn;
		i_interrupt             = intr;
		i_data_access           = dacc;
		i_write_enable          = we;
		i_address               = maddr;
		i_write_data            = wdata;
		i_read_data             = rdata;
		i_byte_enable           = be;
	endtask

	task automatic drive_idle(input int n);
		for (int i = 0; i < n; i++)
			apply_cycle(1'b0, 1'b0, 1'b0, '0, '0, 3'd0, 1'b0, 1'b0, '0, '0, '0, 4'h0);
	endtask

	// ==================================================
	// Compare tasks
	// ==================================================
	task automatic check_exec(input trace_rec_t got, input trace_rec_t exp);
		insn_class_e gc;
		insn_class_e ec;
		mnemonic_e   gm;
		mnemonic_e   em;
		gc = got.insn_class;
		ec = exp.insn_class;
		gm = got.mnemonic;
		em = exp.mnemonic;
		n_checks++;
		if (got.kind != exp.kind || got.seq != exp.seq) begin
			$display("[FAIL] o_trace.kind/seq got %h/%h exp %h/%h",
				got.kind, got.seq, exp.kind, exp.seq);
			n_errors++;
		end
		if (got.address != exp.address || got.data != exp.data ||
				got.byte_en != exp.byte_en) begin
			$display("[FAIL] o_trace.address/data/byte_en got %h/%h/%h exp %h/%h/%h",
				got.address, got.data, got.byte_en, exp.address, exp.data, exp.byte_en);
			n_errors++;
		end
		if (gc != ec) begin
			$display("[FAIL] o_trace.insn_class got %h exp %h at %h", gc, ec, exp.address);
			n_errors++;
		end
		if (gm != em) begin
			$display("[FAIL] o_trace.mnemonic got %h exp %h at %h", gm, em, exp.address);
			n_errors++;
		end
	endtask

	task automatic check_mem(input trace_rec_t got, input trace_rec_t exp);
		n_checks++;
		if (got.kind != exp.kind || got.seq != exp.seq) begin
			$display("[FAIL] o_trace.kind/seq got %h/%h exp %h/%h",
				got.kind, got.seq, exp.kind, exp.seq);
			n_errors++;
		end
		if (got.address != exp.address || got.data != exp.data ||
				got.byte_en != exp.byte_en) begin
			$display("[FAIL] o_trace.address/data/byte_en got %h/%h/%h exp %h/%h/%h",
				got.address, got.data, got.byte_en, exp.address, exp.data, exp.byte_en);
			n_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] %s got %h exp %h", name, got, exp);
			n_errors++;
		end
	endtask

	// Outputs are sampled mid-cycle
	always @(negedge i_clk) begin
		if (i_arst_n && o_trace_valid) begin
			if (exp_q.size() == 0) begin
				$display("Trace record seq %h arrived with nothing expected", o_trace.seq);
				n_errors++;
			end else if (exp_q[0].kind == TRK_EXEC) begin
				check_exec(o_trace, exp_q.pop_front());
			end else begin
				check_mem(o_trace, exp_q.pop_front());
			end
		end
	end

	initial begin : watchdog
		wait (stim_lines != 0);
		#(stim_lines * 8 * CLK_PERIOD);
		$display("Timeout with %0d expected records still pending", exp_q.size());
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin : main
		int          fd;
		int          code;
		int          idle;
		int          wait_cycles;
		logic        done;
		logic [7:0]  tag;
		string       skip;
		logic [31:0] v [13];
		logic [31:0] e [7];
		trace_rec_t  exp;

		i_arst_n = 1'b0;
		i_fetch_stall = 1'b0;
		i_instruction = '0;
		i_instruction_valid = 1'b0;
		i_instruction_address = '0;
		i_instruction_undefined = 1'b0;
		i_interrupt = 3'd0;
		i_data_access = 1'b0;
		i_write_enable = 1'b0;
		i_address = '0;
		i_write_data = '0;
		i_read_data = '0;
		i_byte_enable = 4'h0;
		n_errors = 0;
		n_checks = 0;
		stim_lines = 0;
		lfsr = 32'h0e4e6a06;
		done = 1'b0;

		fd = $fopen(STIM_PATH, "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file %s", STIM_PATH);
			$display("SOME TESTS FAILED");
			$finish;
		end
		// First pass sizes the watchdog
		while (!$feof(fd)) begin
			code = $fgets(skip, fd);
			stim_lines++;
		end
		$fclose(fd);
		fd = $fopen(STIM_PATH, "r");

		repeat (4) @(posedge i_clk);
		#2;
		i_arst_n = 1'b1;

		while (!done) begin
			code = $fscanf(fd, " %c", tag);
			if (code != 1) begin
				done = 1'b1;
			end else if (tag == "#") begin
				code = $fgets(skip, fd);
			end else if (tag == "C") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6],
					v[7], v[8], v[9], v[10], v[11], v[12]);
				apply_cycle(v[0][0], v[1][0], v[2][0], v[3], v[4], v[5][2:0],
					v[6][0], v[7][0], v[8], v[9], v[10], v[11][3:0]);
				if (v[12][0]) begin
					take_bits(2, idle);
					drive_idle(idle);
				end
			end else if (tag == "E") begin
				code = $fscanf(fd, "%h %h %h %h %h %h %h",
					e[0], e[1], e[2], e[3], e[4], e[5], e[6]);
				exp.kind       = trace_kind_e'(e[0][1:0]);
				exp.seq        = e[1][SEQ_W-1:0];
				exp.address    = e[2];
				exp.data       = e[3];
				exp.insn_class = insn_class_e'(e[4][3:0]);
				exp.mnemonic   = mnemonic_e'(e[5][5:0]);
				exp.byte_en    = e[6][3:0];
				exp_q.push_back(exp);
			end else if (tag == "I") begin
				code = $fscanf(fd, "%h", v[0]);
				drive_idle(int'(v[0][7:0]));
			end else if (tag == "F") begin
				code = $fscanf(fd, "%h", v[0]);
				check_flag("o_overflow", o_overflow, v[0][0]);
			end else begin
				$display("Unknown line type in the stimulus file");
				n_errors++;
				code = $fgets(skip, fd);
			end
		end
		$fclose(fd);

		// Let the queue drain, then catch stray records
		wait_cycles = 0;
		while (exp_q.size() != 0 && wait_cycles < 40) begin
			drive_idle(1);
			wait_cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d expected records never appeared", exp_q.size());
			n_errors++;
		end
		drive_idle(10);

		$display("Checks: %0d  errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/trace_stim.txt ====
# C stall valid undef iaddr insn intr dacc we maddr wdata rdata be rnd_idle
# E kind seq addr data class mnem be / I idle_cycles / F overflow (all hex)
C 0 1 0 100 e2000001 0 0 0 0 0 0 0 1
E 0 00 100 e2000001 0 02 0
C 0 1 0 104 e2200001 0 0 0 0 0 0 0 1
E 0 01 104 e2200001 0 09 0
C 0 1 0 108 e2400001 0 0 0 0 0 0 0 1
E 0 02 108 e2400001 0 1c 0
C 0 1 0 10c e2600001 0 0 0 0 0 0 0 1
E 0 03 10c e2600001 0 15 0
C 0 1 0 110 e2800001 0 0 0 0 0 0 0 1
E 0 04 110 e2800001 0 01 0
C 0 1 0 114 e2a00001 0 0 0 0 0 0 0 1
E 0 05 114 e2a00001 0 00 0
C 0 1 0 118 e2c00001 0 0 0 0 0 0 0 1
E 0 06 118 e2c00001 0 17 0
C 0 1 0 11c e2e00001 0 0 0 0 0 0 0 1
E 0 07 11c e2e00001 0 16 0
C 0 1 0 120 e3100001 0 0 0 0 0 0 0 1
E 0 08 120 e3100001 0 21 0
C 0 1 0 124 e3300001 0 0 0 0 0 0 0 1
E 0 09 124 e3300001 0 20 0
C 0 1 0 128 e3500001 0 0 0 0 0 0 0 1
E 0 0a 128 e3500001 0 08 0
C 0 1 0 12c e3700001 0 0 0 0 0 0 0 1
E 0 0b 12c e3700001 0 07 0
C 0 1 0 130 e3800001 0 0 0 0 0 0 0 1
E 0 0c 130 e3800001 0 14 0
C 0 1 0 134 e3a00001 0 0 0 0 0 0 0 1
E 0 0d 134 e3a00001 0 10 0
C 0 1 0 138 e3c00001 0 0 0 0 0 0 0 1
E 0 0e 138 e3c00001 0 04 0
C 0 1 0 13c e3e00001 0 0 0 0 0 0 0 1
E 0 0f 13c e3e00001 0 13 0
C 0 1 0 140 e0000291 0 0 0 0 0 0 0 1
E 0 10 140 e0000291 1 12 0
C 0 1 0 144 e0200291 0 0 0 0 0 0 0 1
E 0 11 144 e0200291 1 0f 0
C 0 1 0 148 e1010092 0 0 0 0 0 0 0 1
E 0 12 148 e1010092 2 1e 0
C 0 1 0 14c e1410092 0 0 0 0 0 0 0 1
E 0 13 14c e1410092 2 1f 0
C 0 1 0 150 e5910000 0 0 0 0 0 0 0 1
E 0 14 150 e5910000 3 0c 0
C 0 1 0 154 e5d10000 0 0 0 0 0 0 0 1
E 0 15 154 e5d10000 3 0d 0
C 0 1 0 158 e5810000 0 0 0 0 0 0 0 1
E 0 16 158 e5810000 3 1a 0
C 0 1 0 15c e5c10000 0 0 0 0 0 0 0 1
E 0 17 15c e5c10000 3 1b 0
C 0 1 0 160 e8910003 0 0 0 0 0 0 0 1
E 0 18 160 e8910003 4 0b 0
C 0 1 0 164 e8810003 0 0 0 0 0 0 0 1
E 0 19 164 e8810003 4 19 0
C 0 1 0 168 ea000004 0 0 0 0 0 0 0 1
E 0 1a 168 ea000004 5 03 0
C 0 1 0 16c eb000004 0 0 0 0 0 0 0 1
E 0 1b 16c eb000004 5 05 0
C 0 1 0 170 ed910100 0 0 0 0 0 0 0 1
E 0 1c 170 ed910100 6 0a 0
C 0 1 0 174 ed810100 0 0 0 0 0 0 0 1
E 0 1d 174 ed810100 6 18 0
C 0 1 0 178 ee000100 0 0 0 0 0 0 0 1
E 0 1e 178 ee000100 7 06 0
C 0 1 0 17c ee000110 0 0 0 0 0 0 0 1
E 0 1f 17c ee000110 8 0e 0
C 0 1 0 180 ee100110 0 0 0 0 0 0 0 1
E 0 20 180 ee100110 8 11 0
C 0 1 0 184 ef000010 0 0 0 0 0 0 0 1
E 0 21 184 ef000010 9 1d 0
C 0 1 1 188 e3a00002 0 0 0 0 0 0 0 1
E 0 22 188 e3a00002 0 22 0
C 1 1 0 18c e3a00003 0 0 0 0 0 0 0 1
C 0 0 0 190 e3a00003 0 0 0 0 0 0 0 1
C 0 1 0 194 e3a00004 3 0 0 0 0 0 0 1
C 0 1 0 198 e3a00005 7 0 0 0 0 0 0 1
E 0 23 198 e3a00005 0 10 0
C 0 0 0 0 0 0 1 0 2000 11111111 cafef00d f 1
E 1 24 2000 cafef00d 0 22 f
C 0 0 0 0 0 0 1 1 2004 12345678 0 3 1
E 2 25 2004 12345678 0 22 3
C 1 0 0 0 0 0 1 1 2008 55555555 0 f 1
C 0 1 0 19c e3a00006 0 0 0 0 0 0 0 0
C 0 0 0 0 0 0 1 0 2008 0 0000beef 1 1
E 0 26 19c e3a00006 0 10 0
E 1 27 2008 0000beef 0 22 1
I 6
F 0
C 0 1 0 1a0 e3a00007 0 0 1 3000 d0000000 0 f 0
C 0 1 0 1a4 e3a00008 0 0 1 3004 d1000000 0 f 0
C 0 1 0 1a8 e3a00009 0 0 1 3008 d2000000 0 f 0
C 0 1 0 1ac e3a0000a 0 0 1 300c d3000000 0 f 0
E 2 28 3000 d0000000 0 22 f
E 0 29 1a0 e3a00007 0 10 0
E 2 2a 3004 d1000000 0 22 f
E 0 2b 1a4 e3a00008 0 10 0
E 2 2c 3008 d2000000 0 22 f
E 0 2d 1a8 e3a00009 0 10 0
E 0 2f 1ac e3a0000a 0 10 0
I 6
F 1

// ==== project.f ====
verilog/arm_isa_pkg.sv
verilog/trace_pkg.sv
verilog/insn_trace_decoder.sv
verilog/mem_access_monitor.sv
verilog/trace_merger.sv
verilog/a23_trace_unit.sv
verification/tb_a23_trace_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_a23_trace_unit
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
